/* common/fetch_pkg.sv */
// shared constants and types for the instruction fetch and pre-decode front end, imported by every unit
package fetch_pkg;

  // queue geometry
  localparam int line_bytes    = 16;
  localparam int buf_lines     = 4;
  localparam int ptr_w         = 6;
  localparam int max_instr_len = 15;
  localparam int off_w         = $clog2(line_bytes);
  localparam int idx_w         = $clog2(buf_lines);

  // fetch restarts here after reset
  localparam logic [31:0] reset_eip = 32'h0000_0000;

  // prefix and escape bytes known to the pre-decoder
  localparam logic [7:0] pfx_opsize = 8'h66;
  localparam logic [7:0] pfx_repne  = 8'hf2;
  localparam logic [7:0] pfx_rep    = 8'hf3;
  localparam logic [7:0] pfx_lock   = 8'hf0;
  localparam logic [7:0] pfx_es     = 8'h26;
  localparam logic [7:0] pfx_cs     = 8'h2e;
  localparam logic [7:0] pfx_ss     = 8'h36;
  localparam logic [7:0] pfx_ds     = 8'h3e;
  localparam logic [7:0] pfx_fs     = 8'h64;
  localparam logic [7:0] pfx_gs     = 8'h65;
  localparam logic [7:0] esc_0f     = 8'h0f;

  typedef logic [31:0] addr_t;

  // byte 0 sits in bits 7:0, so bytes run in ascending address order
  typedef logic [8*line_bytes-1:0] line_t;

  // icache request carries a line-aligned address
  typedef struct packed {
    addr_t addr;
  } ic_req_t;

  typedef struct packed {
    line_t data;
  } ic_rsp_t;

  typedef struct packed {
    addr_t target;
  } redirect_t;

  // one pre-decoded instruction as handed to the decode stage
  typedef struct packed {
    addr_t                                eip;
    logic [$clog2(max_instr_len+1)-1:0]   length;
    logic [1:0]                           prefix_count;
    logic                                 operand_override;
    logic                                 repeat_prefix;
    logic                                 segment_override;
    logic [2:0]                           seg_id;
    logic                                 two_byte_opcode;
    logic [7:0]                           opcode;
    logic                                 modrm_present;
    logic [7:0]                           modrm;
    logic                                 sib_present;
    logic [7:0]                           sib;
    // byte counts, 0, 1 or 4 for disp and 0, 1, 2 or 4 for imm
    logic [2:0]                           disp_size;
    logic [31:0]                          disp;
    logic [2:0]                           imm_size;
    logic [31:0]                          imm;
    logic                                 unsupported;
  } instr_t;

endpackage

/* fetch/fetch_buffer.sv */
// four-line instruction queue that requests icache lines, drops stale fills and tracks the read pointer
module fetch_buffer
  import fetch_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  output logic             ic_req_valid,
  output ic_req_t          ic_req,
  input  logic             ic_req_ready,
  input  logic             ic_rsp_valid,
  input  ic_rsp_t          ic_rsp,
  input  logic             redirect_valid,
  input  redirect_t        redirect,
  input  logic             consume,
  input  logic [off_w-1:0] consume_len,
  output line_t [1:0]      window_lines,
  output logic [ptr_w-1:0] read_ptr,
  output addr_t            window_eip,
  output logic             window_valid
);

  line_t                lines [buf_lines];
  logic [buf_lines-1:0] line_valid;
  logic [idx_w-1:0]     fill_idx;
  addr_t                req_addr;
  logic [2:0]           outstanding;
  logic [3:0]           drop_cnt;
  logic                 running;

  logic [idx_w-1:0]     head;
  logic [idx_w-1:0]     head_nxt;
  logic                 req_fire;
  logic                 rsp_take;
  logic                 rsp_drop;
  logic [2:0]           valid_cnt;
  logic                 slot_free;
  line_t                view [buf_lines];
  logic [buf_lines-1:0] view_valid;
  logic [off_w:0]       off_sum;
  logic                 free_head;

  // upper pointer bits select the head line
  assign head     = read_ptr[ptr_w-1 -: idx_w];
  assign head_nxt = head + 1'b1;

  assign req_fire = ic_req_valid && ic_req_ready;
  assign rsp_drop = ic_rsp_valid && (drop_cnt != 4'd0);
  assign rsp_take = ic_rsp_valid && (drop_cnt == 4'd0);

  always_comb
  begin
    valid_cnt = 3'd0;
    for (int i = 0; i < buf_lines; i++)
      valid_cnt = valid_cnt + 3'(line_valid[i]);
  end

  // a request only goes out once a slot is reserved for its line
  assign slot_free    = ({1'b0, valid_cnt} + {1'b0, outstanding}) < 4'(buf_lines);
  assign ic_req_valid = running && slot_free && !drop_cnt[3];
  assign ic_req.addr  = req_addr;

  // a fill arriving this cycle is already visible to the window
  always_comb
  begin
    for (int i = 0; i < buf_lines; i++)
    begin
      view[i]       = lines[i];
      view_valid[i] = line_valid[i];
      if (rsp_take && (fill_idx == idx_w'(i)))
      begin
        view[i]       = ic_rsp.data;
        view_valid[i] = 1'b1;
      end
    end
  end

  assign window_lines[0] = view[head];
  assign window_lines[1] = view[head_nxt];
  assign window_valid    = view_valid[head] && view_valid[head_nxt];

  // head line is done once the pointer steps past byte 15
  assign off_sum   = {1'b0, read_ptr[off_w-1:0]} + {1'b0, consume_len};
  assign free_head = consume && off_sum[off_w];

  always_ff @(posedge clk)
  begin
    if (rsp_take)
      lines[fill_idx] <= ic_rsp.data;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      running     <= 1'b0;
      line_valid  <= '0;
      fill_idx    <= '0;
      req_addr    <= {reset_eip[31:off_w], {off_w{1'b0}}};
      outstanding <= 3'd0;
      drop_cnt    <= 4'd0;
      read_ptr    <= ptr_w'(reset_eip[off_w-1:0]);
      window_eip  <= reset_eip;
    end
    else
    begin
      running <= 1'b1;
      if (redirect_valid)
      begin
        // everything still owed becomes stale, including a request taken this cycle
        line_valid  <= '0;
        fill_idx    <= '0;
        req_addr    <= {redirect.target[31:off_w], {off_w{1'b0}}};
        read_ptr    <= ptr_w'(redirect.target[off_w-1:0]);
        window_eip  <= redirect.target;
        outstanding <= 3'd0;
        drop_cnt    <= drop_cnt - 4'(rsp_drop) + 4'(outstanding) + 4'(req_fire)
                       - 4'(rsp_take);
      end
      else
      begin
        if (rsp_take)
        begin
          line_valid[fill_idx] <= 1'b1;
          fill_idx             <= fill_idx + 1'b1;
        end
        // freeing wins over a fill into the same slot
        if (free_head)
          line_valid[head] <= 1'b0;
        if (req_fire)
          req_addr <= req_addr + addr_t'(line_bytes);
        outstanding <= outstanding + 3'(req_fire) - 3'(rsp_take);
        drop_cnt    <= drop_cnt - 4'(rsp_drop);
        if (consume)
        begin
          read_ptr   <= read_ptr + ptr_w'(consume_len);
          window_eip <= window_eip + addr_t'(consume_len);
        end
      end
    end
  end

endmodule

/* fetch/fetch_aligner.sv */
// byte rotator that cuts the 16-byte instruction window out of the two lines under the read pointer
module fetch_aligner
  import fetch_pkg::*;
(
  input  line_t [1:0]      lines,
  input  logic [off_w-1:0] offset,
  output line_t            window
);

  logic [2*$bits(line_t)-1:0] both;
  logic [$bits(line_t)+23:0]  word_step;

  // head line in the low half, the following line above it
  assign both = lines;

  always_comb
  begin
    // coarse level, whole 4-byte words
    case (offset[3:2])
      2'd0:    word_step = both[151:0];
      2'd1:    word_step = both[183:32];
      2'd2:    word_step = both[215:64];
      default: word_step = both[247:96];
    endcase

    // fine level, single bytes
    case (offset[1:0])
      2'd0:    window = word_step[127:0];
      2'd1:    window = word_step[135:8];
      2'd2:    window = word_step[143:16];
      default: window = word_step[151:24];
    endcase
  end

endmodule

/* hdl/predecode.sv */
// pre-decoder that sizes one IA-32 instruction in the fetch window and holds it in a valid/ready output register
module predecode
  import fetch_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  line_t            window,
  input  addr_t            window_eip,
  input  logic             window_valid,
  input  logic             flush,
  output logic             instr_valid,
  output instr_t           instr,
  input  logic             instr_ready,
  output logic             consume,
  output logic [off_w-1:0] consume_len
);

  instr_t     dec;
  logic [7:0] b0;
  logic [7:0] b1;
  logic [7:0] b2;
  logic [7:0] pb;
  logic [3:0] seg;
  logic [1:0] pcount;
  logic       esc;
  logic [2:0] imm_full;
  logic [7:0] op_byte;
  logic [7:0] modrm_byte;
  logic [7:0] sib_byte;
  logic [4:0] op_pos;
  logic [4:0] modrm_pos;
  logic [4:0] disp_pos;
  logic [4:0] imm_pos;
  logic [4:0] len_sum;
  logic       load;

  // bytes past the end of the window read as zero
  function automatic logic [7:0] byte_at(line_t w, logic [4:0] pos);
    logic [7:0] b;
    b = 8'h00;
    if (pos < 5'(line_bytes))
      b = w[pos[3:0]*8 +: 8];
    return b;
  endfunction

  function automatic logic is_prefix(logic [7:0] b);
    case (b)
      pfx_opsize, pfx_repne, pfx_rep, pfx_lock,
      pfx_es, pfx_cs, pfx_ss, pfx_ds, pfx_fs, pfx_gs:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // hit bit on top, segment number below
  function automatic logic [3:0] seg_of(logic [7:0] b);
    case (b)
      pfx_es:  return 4'b1_000;
      pfx_cs:  return 4'b1_001;
      pfx_ss:  return 4'b1_010;
      pfx_ds:  return 4'b1_011;
      pfx_fs:  return 4'b1_100;
      pfx_gs:  return 4'b1_101;
      default: return 4'b0_000;
    endcase
  endfunction

  // little-endian field of size bytes starting at pos
  function automatic logic [31:0] le_field(line_t w, logic [4:0] pos, logic [2:0] size);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < 4; k++)
      if (k < size)
        v[k*8 +: 8] = byte_at(w, pos + 5'(k));
    return v;
  endfunction

  always_comb
  begin
    dec = '0;
    b0  = byte_at(window, 5'd0);
    b1  = byte_at(window, 5'd1);
    b2  = byte_at(window, 5'd2);
    pb  = 8'h00;
    seg = 4'b0;

    // prefixes count only while they run unbroken from byte 0
    pcount = 2'd0;
    if (is_prefix(b0))
    begin
      pcount = 2'd1;
      if (is_prefix(b1))
      begin
        pcount = 2'd2;
        if (is_prefix(b2))
          pcount = 2'd3;
      end
    end

    for (int i = 0; i < 3; i++)
    begin
      if (2'(i) < pcount)
      begin
        pb  = byte_at(window, 5'(i));
        seg = seg_of(pb);
        if (pb == pfx_opsize)
          dec.operand_override = 1'b1;
        if ((pb == pfx_repne) || (pb == pfx_rep))
          dec.repeat_prefix = 1'b1;
        // last segment prefix wins
        if (seg[3])
        begin
          dec.segment_override = 1'b1;
          dec.seg_id           = seg[2:0];
        end
      end
    end

    esc        = (byte_at(window, 5'(pcount)) == esc_0f);
    op_pos     = 5'(pcount) + 5'(esc);
    op_byte    = byte_at(window, op_pos);
    modrm_pos  = op_pos + 5'd1;
    modrm_byte = byte_at(window, modrm_pos);
    sib_byte   = byte_at(window, modrm_pos + 5'd1);
    imm_full   = dec.operand_override ? 3'd2 : 3'd4;

    // operand layout of the supported subset
    if (esc)
    begin
      if (op_byte[7:4] == 4'h8)
        dec.imm_size = 3'd4;
      else if (op_byte == 8'haf)
        dec.modrm_present = 1'b1;
      else
        dec.unsupported = 1'b1;
    end
    else if (op_byte < 8'h40)
    begin
      case (op_byte[2:0])
        3'd0, 3'd1, 3'd2, 3'd3: dec.modrm_present = 1'b1;
        3'd4:                   dec.imm_size = 3'd1;
        3'd5:                   dec.imm_size = imm_full;
        default:                dec.unsupported = 1'b1;
      endcase
    end
    else
    begin
      case (op_byte) inside
        [8'h40:8'h5f], 8'h90, 8'hc3:
          dec.imm_size = 3'd0;
        [8'h70:8'h7f], 8'heb:
          dec.imm_size = 3'd1;
        8'h80, 8'h83:
        begin
          dec.modrm_present = 1'b1;
          dec.imm_size      = 3'd1;
        end
        8'h81:
        begin
          dec.modrm_present = 1'b1;
          dec.imm_size      = imm_full;
        end
        [8'h88:8'h8b]:
          dec.modrm_present = 1'b1;
        [8'hb8:8'hbf]:
          dec.imm_size = imm_full;
        8'he8, 8'he9:
          dec.imm_size = 3'd4;
        default:
          dec.unsupported = 1'b1;
      endcase
    end

    // 32-bit addressing forms
    if (dec.modrm_present)
    begin
      dec.modrm       = modrm_byte;
      dec.sib_present = (modrm_byte[2:0] == 3'd4) && (modrm_byte[7:6] != 2'd3);
      if (dec.sib_present)
        dec.sib = sib_byte;
      if (modrm_byte[7:6] == 2'd1)
        dec.disp_size = 3'd1;
      else if ((modrm_byte[7:6] == 2'd2) ||
               ((modrm_byte[7:6] == 2'd0) && (modrm_byte[2:0] == 3'd5)) ||
               ((modrm_byte[7:6] == 2'd0) && dec.sib_present && (sib_byte[2:0] == 3'd5)))
        dec.disp_size = 3'd4;
    end

    disp_pos = modrm_pos + 5'(dec.modrm_present) + 5'(dec.sib_present);
    imm_pos  = disp_pos + 5'(dec.disp_size);
    len_sum  = imm_pos + 5'(dec.imm_size);

    dec.disp            = le_field(window, disp_pos, dec.disp_size);
    dec.imm             = le_field(window, imm_pos, dec.imm_size);
    dec.eip             = window_eip;
    dec.length          = len_sum[3:0];
    dec.prefix_count    = pcount;
    dec.two_byte_opcode = esc;
    dec.opcode          = op_byte;
  end

  // load when the register is empty or drains this cycle
  assign load        = window_valid && !flush && (!instr_valid || instr_ready);
  assign consume     = load;
  assign consume_len = dec.length;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      instr_valid <= 1'b0;
    else if (flush)
      instr_valid <= 1'b0;
    else if (load)
      instr_valid <= 1'b1;
    else if (instr_ready)
      instr_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      instr <= dec;
  end

endmodule

/* hdl/fetch_top.sv */
// fetch front end top level joining the line queue, byte rotator and pre-decoder to the icache and decode ports
module fetch_top
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  output logic      ic_req_valid,
  output ic_req_t   ic_req,
  input  logic      ic_req_ready,
  input  logic      ic_rsp_valid,
  input  ic_rsp_t   ic_rsp,
  input  logic      redirect_valid,
  input  redirect_t redirect,
  output logic      instr_valid,
  output instr_t    instr,
  input  logic      instr_ready
);

  line_t [1:0]      window_lines;
  logic [ptr_w-1:0] read_ptr;
  addr_t            window_eip;
  logic             window_valid;
  line_t            window;
  logic             consume;
  logic [off_w-1:0] consume_len;

  fetch_buffer u_fetch_buffer (
    .clk            (clk),
    .arst_n         (arst_n),
    .ic_req_valid   (ic_req_valid),
    .ic_req         (ic_req),
    .ic_req_ready   (ic_req_ready),
    .ic_rsp_valid   (ic_rsp_valid),
    .ic_rsp         (ic_rsp),
    .redirect_valid (redirect_valid),
    .redirect       (redirect),
    .consume        (consume),
    .consume_len    (consume_len),
    .window_lines   (window_lines),
    .read_ptr       (read_ptr),
    .window_eip     (window_eip),
    .window_valid   (window_valid)
  );

  // only the byte offset within the head line steers the rotator
  fetch_aligner u_fetch_aligner (
    .lines  (window_lines),
    .offset (read_ptr[off_w-1:0]),
    .window (window)
  );

  predecode u_predecode (
    .clk          (clk),
    .arst_n       (arst_n),
    .window       (window),
    .window_eip   (window_eip),
    .window_valid (window_valid),
    .flush        (redirect_valid),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .consume      (consume),
    .consume_len  (consume_len)
  );

endmodule

/* testbench/fetch_sva.sv */
// concurrent checks on the icache request and decode output handshakes, bound into fetch_top
module fetch_sva
  import fetch_pkg::*;
(
  input logic    clk,
  input logic    arst_n,
  input logic    ic_req_valid,
  input ic_req_t ic_req,
  input logic    ic_req_ready,
  input logic    redirect_valid,
  input logic    instr_valid,
  input instr_t  instr,
  input logic    instr_ready
);

  int fail_count = 0;

  // a waiting request keeps its address unless a redirect retargets fetch
  req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    ic_req_valid && !ic_req_ready && !redirect_valid |=> ic_req_valid && $stable(ic_req))
  else
  begin
    $error("icache request changed while waiting");
    fail_count++;
  end

  // stalled output holds until taken or flushed
  instr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid && !instr_ready && !redirect_valid |=> instr_valid && $stable(instr))
  else
  begin
    $error("decode output changed under back-pressure");
    fail_count++;
  end

  length_range: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid |-> (instr.length != 0) && (instr.length <= max_instr_len))
  else
  begin
    $error("instruction length out of range");
    fail_count++;
  end

endmodule

/* testbench/fetch_tb.sv */
// self-checking testbench for the fetch front end with an icache model and a decode table
module fetch_tb
  import fetch_pkg::*;
();

  localparam int mem_bytes = 512;
  localparam int max_rows  = 32;

  // a redirect marker carries its target in exp.eip
  typedef struct packed {
    logic         redir;
    logic [119:0] enc;
    instr_t       exp;
  } row_t;

  logic      clk;
  logic      arst_n;
  logic      ic_req_valid;
  ic_req_t   ic_req;
  logic      ic_req_ready;
  logic      ic_rsp_valid;
  ic_rsp_t   ic_rsp;
  logic      redirect_valid;
  redirect_t redirect;
  logic      instr_valid;
  instr_t    instr;
  logic      instr_ready;

  logic [7:0] mem [mem_bytes];
  row_t       rows [max_rows];
  int         n_rows;
  addr_t      lay_addr;
  integer     seed;
  addr_t      req_q [$];
  int         due_q [$];
  int         delay;
  int         last_due;
  addr_t      exp_req_addr;
  int         cycle;
  int         timeout_cycles;
  int         row_idx;
  int         row_errs;
  int         rows_checked;
  int         errors;
  logic       finished;
  logic       timed_out;

  fetch_top i_fetch_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .ic_req_valid   (ic_req_valid),
    .ic_req         (ic_req),
    .ic_req_ready   (ic_req_ready),
    .ic_rsp_valid   (ic_rsp_valid),
    .ic_rsp         (ic_rsp),
    .redirect_valid (redirect_valid),
    .redirect       (redirect),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_ready    (instr_ready)
  );

  bind fetch_top fetch_sva i_fetch_sva (
    .clk            (clk),
    .arst_n         (arst_n),
    .ic_req_valid   (ic_req_valid),
    .ic_req         (ic_req),
    .ic_req_ready   (ic_req_ready),
    .redirect_valid (redirect_valid),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_ready    (instr_ready)
  );

  always #2 clk = ~clk;

  // background bytes mixed from both address bytes
  function automatic logic [7:0] fill_byte(int a);
    return 8'(a * 37) ^ 8'((a >> 8) * 91);
  endfunction

  function automatic line_t line_at(addr_t a);
    line_t l;
    for (int k = 0; k < line_bytes; k++)
      l[8*k +: 8] = mem[(int'(a) + k) % mem_bytes];
    return l;
  endfunction

  // enc lists the bytes with the first byte leftmost
  // a seg, modrm or sib of -1 means the field is absent
  task automatic add_instr(input logic [119:0] enc, input int len, input logic [1:0] pfx,
                           input logic opsz, input logic rep, input int seg, input logic esc,
                           input logic [7:0] op, input int modrm, input int sib, input int dsz,
                           input logic [31:0] disp, input int isz, input logic [31:0] imm,
                           input logic unsup);
    row_t r;
    r                      = '0;
    r.enc                  = enc;
    r.exp.eip              = lay_addr;
    r.exp.length           = 4'(len);
    r.exp.prefix_count     = pfx;
    r.exp.operand_override = opsz;
    r.exp.repeat_prefix    = rep;
    r.exp.segment_override = (seg >= 0);
    r.exp.seg_id           = (seg >= 0) ? 3'(seg) : 3'd0;
    r.exp.two_byte_opcode  = esc;
    r.exp.opcode           = op;
    r.exp.modrm_present    = (modrm >= 0);
    r.exp.modrm            = (modrm >= 0) ? 8'(modrm) : 8'h00;
    r.exp.sib_present      = (sib >= 0);
    r.exp.sib              = (sib >= 0) ? 8'(sib) : 8'h00;
    r.exp.disp_size        = 3'(dsz);
    r.exp.disp             = disp;
    r.exp.imm_size         = 3'(isz);
    r.exp.imm              = imm;
    r.exp.unsupported      = unsup;
    for (int k = 0; k < len; k++)
      mem[(int'(lay_addr) + k) % mem_bytes] = enc[8*(len-1-k) +: 8];
    rows[n_rows] = r;
    n_rows++;
    lay_addr = lay_addr + addr_t'(len);
  endtask

  task automatic add_redirect(input addr_t target);
    row_t r;
    r            = '0;
    r.redir      = 1'b1;
    r.exp.eip    = target;
    rows[n_rows] = r;
    n_rows++;
    lay_addr = target;
  endtask

  task automatic build_table();
    for (int a = 0; a < mem_bytes; a++)
      mem[a] = fill_byte(a);
    n_rows   = 0;
    lay_addr = reset_eip;
    // enc, len, pfx, 66, rep, seg, 0f, opcode, modrm, sib, disp size, disp, imm size, imm, unsup
    add_instr(120'h90, 1, 0, 0, 0, -1, 0, 8'h90, -1, -1, 0, 0, 0, 0, 0);
    add_instr(120'h50, 1, 0, 0, 0, -1, 0, 8'h50, -1, -1, 0, 0, 0, 0, 0);
    add_instr(120'h89d8, 2, 0, 0, 0, -1, 0, 8'h89, 'hd8, -1, 0, 0, 0, 0, 0);
    add_instr(120'hc3, 1, 0, 0, 0, -1, 0, 8'hc3, -1, -1, 0, 0, 0, 0, 0);
    // prefix forms where 66 shrinks the immediate to two bytes
    add_instr(120'h66b83412, 4, 1, 1, 0, -1, 0, 8'hb8, -1, -1, 0, 0, 2, 'h1234, 0);
    add_instr(120'hf390, 2, 1, 0, 1, -1, 0, 8'h90, -1, -1, 0, 0, 0, 0, 0);
    add_instr(120'h648b03, 3, 1, 0, 0, 4, 0, 8'h8b, 'h03, -1, 0, 0, 0, 0, 0);
    add_instr(120'h2e6681c17856, 6, 2, 1, 0, 1, 0, 8'h81, 'hc1, -1, 0, 0, 2, 'h5678, 0);
    add_instr(120'hf23e260544332211, 8, 3, 0, 1, 0, 0, 8'h05, -1, -1, 0, 0,
              4, 'h11223344, 0);
    // addressing forms
    add_instr(120'h8b048b, 3, 0, 0, 0, -1, 0, 8'h8b, 'h04, 'h8b, 0, 0, 0, 0, 0);
    add_instr(120'h8b45fc, 3, 0, 0, 0, -1, 0, 8'h8b, 'h45, -1, 1, 'hfc, 0, 0, 0);
    add_instr(120'h8b0d78563412, 6, 0, 0, 0, -1, 0, 8'h8b, 'h0d, -1, 4, 'h12345678, 0, 0, 0);
    add_instr(120'h8b048d00100000, 7, 0, 0, 0, -1, 0, 8'h8b, 'h04, 'h8d, 4, 'h1000, 0, 0, 0);
    add_instr(120'h89842410000000, 7, 0, 0, 0, -1, 0, 8'h89, 'h84, 'h24, 4, 'h10, 0, 0, 0);
    // immediates and instructions that straddle a line
    add_instr(120'he800010000, 5, 0, 0, 0, -1, 0, 8'he8, -1, -1, 0, 0, 4, 'h100, 0);
    add_instr(120'h0f8410000000, 6, 0, 0, 0, -1, 1, 8'h84, -1, -1, 0, 0, 4, 'h10, 0);
    add_instr(120'h0fafc3, 3, 0, 0, 0, -1, 1, 8'haf, 'hc3, -1, 0, 0, 0, 0, 0);
    add_instr(120'h83c001, 3, 0, 0, 0, -1, 0, 8'h83, 'hc0, -1, 0, 0, 1, 'h01, 0);
    add_instr(120'h81bc2480000000efbeadde, 11, 0, 0, 0, -1, 0, 8'h81, 'hbc, 'h24,
              4, 'h80, 4, 'hdeadbeef, 0);
    add_instr(120'h3e8b848d00200000, 8, 1, 0, 0, 3, 0, 8'h8b, 'h84, 'h8d, 4, 'h2000, 0, 0, 0);
    add_instr(120'h75f0, 2, 0, 0, 0, -1, 0, 8'h75, -1, -1, 0, 0, 1, 'hf0, 0);
    add_instr(120'hebfe, 2, 0, 0, 0, -1, 0, 8'heb, -1, -1, 0, 0, 1, 'hfe, 0);
    // opcodes outside the subset
    add_instr(120'hf4, 1, 0, 0, 0, -1, 0, 8'hf4, -1, -1, 0, 0, 0, 0, 1);
    add_instr(120'h66f0d9, 3, 2, 1, 0, -1, 0, 8'hd9, -1, -1, 0, 0, 0, 0, 1);
    add_redirect(32'h100);
    add_instr(120'hb90a000000, 5, 0, 0, 0, -1, 0, 8'hb9, -1, -1, 0, 0, 4, 'h0a, 0);
    add_instr(120'h260f85fcffffff, 7, 1, 0, 0, 0, 1, 8'h85, -1, -1, 0, 0, 4, 'hfffffffc, 0);
    add_instr(120'h90, 1, 0, 0, 0, -1, 0, 8'h90, -1, -1, 0, 0, 0, 0, 0);
    add_instr(120'h047f, 2, 0, 0, 0, -1, 0, 8'h04, -1, -1, 0, 0, 1, 'h7f, 0);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      row_errs++;
    end
  endtask

  task automatic check_row(input int idx);
    instr_t e;
    e        = rows[idx].exp;
    row_errs = 0;
    compare_field("instr.eip", instr.eip, e.eip);
    compare_field("instr.length", instr.length, e.length);
    compare_field("instr.prefix_count", instr.prefix_count, e.prefix_count);
    compare_field("instr.operand_override", instr.operand_override, e.operand_override);
    compare_field("instr.repeat_prefix", instr.repeat_prefix, e.repeat_prefix);
    compare_field("instr.segment_override", instr.segment_override, e.segment_override);
    compare_field("instr.seg_id", instr.seg_id, e.seg_id);
    compare_field("instr.two_byte_opcode", instr.two_byte_opcode, e.two_byte_opcode);
    compare_field("instr.opcode", instr.opcode, e.opcode);
    compare_field("instr.modrm_present", instr.modrm_present, e.modrm_present);
    compare_field("instr.modrm", instr.modrm, e.modrm);
    compare_field("instr.sib_present", instr.sib_present, e.sib_present);
    compare_field("instr.sib", instr.sib, e.sib);
    compare_field("instr.disp_size", instr.disp_size, e.disp_size);
    compare_field("instr.disp", instr.disp, e.disp);
    compare_field("instr.imm_size", instr.imm_size, e.imm_size);
    compare_field("instr.imm", instr.imm, e.imm);
    compare_field("instr.unsupported", instr.unsupported, e.unsupported);
    if (row_errs == 0)
      $display("row %0d at %h, length %0d ok", idx, e.eip, e.length);
    else
      $display("row %0d at %h, %0d fields wrong", idx, e.eip, row_errs);
    errors += row_errs;
    rows_checked++;
  endtask

  always @(posedge clk)
  begin
    if (arst_n && !finished && !timed_out)
    begin
      cycle = cycle + 1;
      // icache model returning responses in request order and at most one per cycle
      if (ic_req_valid && ic_req_ready)
      begin
        if (ic_req.addr !== exp_req_addr)
        begin
          $display("CHECK FAILED t=%0t ic_req.addr got %h expected %h", $time, ic_req.addr,
                   exp_req_addr);
          errors++;
        end
        exp_req_addr = exp_req_addr + addr_t'(line_bytes);
        delay    = 1 + int'($unsigned($random(seed)) % 4);
        last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
        req_q.push_back(ic_req.addr);
        due_q.push_back(last_due);
      end
      // fetch restarts at the line holding the redirect target
      if (redirect_valid)
        exp_req_addr = redirect.target & ~addr_t'(line_bytes - 1);
      if ((due_q.size() > 0) && (due_q[0] <= cycle))
      begin
        ic_rsp_valid <= 1'b1;
        ic_rsp.data  <= line_at(req_q.pop_front());
        void'(due_q.pop_front());
      end
      else
        ic_rsp_valid <= 1'b0;
      ic_req_ready <= 1'($random(seed));

      if (instr_valid && instr_ready)
      begin
        check_row(row_idx);
        row_idx++;
      end
      // hold off decode while the redirect pulse flushes the output register
      if ((row_idx < n_rows) && rows[row_idx].redir)
      begin
        redirect_valid  <= 1'b1;
        redirect.target <= rows[row_idx].exp.eip;
        instr_ready     <= 1'b0;
        row_idx++;
      end
      else
      begin
        redirect_valid <= 1'b0;
        instr_ready    <= 1'($random(seed));
      end
      if (row_idx >= n_rows)
        finished = 1'b1;
      if (cycle >= timeout_cycles)
        timed_out = 1'b1;
    end
  end

  initial
  begin
    seed = 9;
    build_table();
    timeout_cycles = n_rows * 12 + 100;
    cycle          = 0;
    last_due       = 0;
    exp_req_addr   = reset_eip & ~addr_t'(line_bytes - 1);
    row_idx        = 0;
    rows_checked   = 0;
    errors         = 0;
    finished       = 1'b0;
    timed_out      = 1'b0;
    clk            = 1'b0;
    arst_n         = 1'b0;
    ic_req_ready   = 1'b0;
    ic_rsp_valid   = 1'b0;
    ic_rsp         = '0;
    redirect_valid = 1'b0;
    redirect       = '0;
    instr_ready    = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    wait (finished || timed_out);
    if (timed_out)
    begin
      $display("timeout after %0d cycles, only %0d of %0d rows reached", cycle, row_idx, n_rows);
      errors++;
    end
    $display("%0d rows checked, %0d check errors, %0d assertion failures",
             rows_checked, errors, i_fetch_top.i_fetch_sva.fail_count);
    if ((errors == 0) && (i_fetch_top.i_fetch_sva.fail_count == 0))
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* fetch_subsys.f */
common/fetch_pkg.sv
fetch/fetch_buffer.sv
fetch/fetch_aligner.sv
hdl/predecode.sv
hdl/fetch_top.sv
testbench/fetch_sva.sv
testbench/fetch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := fetch_subsys.f
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := Regression passed
SIM        := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf obj_dir
